//--- rtl/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Operand and result width
`define EXEC_DATA_W	32

`define EXEC_TAG_W	6	// Destination register tag

// Power-of-two entry count per unit result buffer
`define EXEC_DEPTH	4

`endif

//--- rtl/execPkg.sv
`include "exec_settings.svh"

package execPkg;

	////////////////////////////////////////
	// Datapath types

	// One operand or one result
	typedef logic [`EXEC_DATA_W-1:0] data_t;

	typedef logic [`EXEC_TAG_W-1:0] tag_t;	// Destination register

	// Bit 1 picks the unit, bit 0 the variant
	// (subtract on the add unit, high half on the multiply unit)
	typedef logic [1:0] opCode_t;

	// Result buffer entry address
	typedef logic [$clog2(`EXEC_DEPTH)-1:0] bufPtr_t;

	////////////////////////////////////////
	// Arbiter state

	// Unit served last by the write-back arbiter
	typedef enum logic {
		grantAdd = 1'b0,
		grantMul = 1'b1
	} grant_t;

endpackage

//--- rtl/execIssueIf.sv
`timescale 1ns/1ps

// One issue into a unit or one result out of it
interface execIssueIf;
	import execPkg::*;

	logic valid;
	data_t data1;	// First operand or the unit result
	data_t data2;	// Second operand and idle on the result side
	opCode_t opCode;
	tag_t tag;

	modport source (
		output valid,
		output data1,
		output data2,
		output opCode,
		output tag
	);

	modport sink (
		input valid,
		input data1,
		input data2,
		input opCode,
		input tag
	);

endinterface

//--- rtl/ringBuffCtrl.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module ringBuffCtrl #(
	parameter int numEntry = `EXEC_DEPTH
)(
	input logic clock,
	input logic reset,
	input logic writeEn,
	input logic readEn,
	output execPkg::bufPtr_t writeAddr,
	output execPkg::bufPtr_t readAddr,
	output logic full,
	output logic empty
);
	import execPkg::*;

	localparam int cntW = $clog2(numEntry + 1);

	logic [cntW-1:0] count;	// Entries in use
	logic doWrite;
	logic doRead;

	// Never write into a full buffer or read from an empty one
	assign doWrite = writeEn & ~full;
	assign doRead = readEn & ~empty;

	assign full = (count == cntW'(numEntry));
	assign empty = (count == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			writeAddr <= '0;
			readAddr <= '0;
			count <= '0;
		end
		else begin
			if (doWrite) begin
				writeAddr <= (writeAddr == bufPtr_t'(numEntry - 1)) ? '0 :
					writeAddr + bufPtr_t'(1);
			end
			if (doRead) begin
				readAddr <= (readAddr == bufPtr_t'(numEntry - 1)) ? '0 :
					readAddr + bufPtr_t'(1);
			end

			// Write and read together keep the count
			case ({doWrite, doRead})
				2'b10: count <= count + cntW'(1);
				2'b01: count <= count - cntW'(1);
				default: count <= count;
			endcase
		end
	end

endmodule

//--- rtl/addUnit.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module addUnit (
	input logic clock,
	input logic reset,
	execIssueIf.sink issue,
	execIssueIf.source result,
	input logic hold,
	output logic busy
);
	import execPkg::*;

	logic isSub;
	data_t resultData;

	logic writeEn;
	logic readEn;
	bufPtr_t writeAddr;
	bufPtr_t readAddr;
	logic full;
	logic empty;

	// Result buffer entries
	data_t bufData [`EXEC_DEPTH];
	tag_t bufTag [`EXEC_DEPTH];
	opCode_t bufOpCode [`EXEC_DEPTH];

	////////////////////////////////////////
	// Compute in the issue cycle

	assign isSub = issue.opCode[0];
	assign resultData = isSub ? issue.data1 - issue.data2 : issue.data1 + issue.data2;

	assign writeEn = issue.valid & ~full;	// Issue into a full buffer is dropped
	assign readEn = ~empty & ~hold;

	always_ff @(posedge clock) begin
		if (writeEn) begin
			bufData[writeAddr] <= resultData;
			bufTag[writeAddr] <= issue.tag;
			bufOpCode[writeAddr] <= issue.opCode;
		end
	end

	////////////////////////////////////////
	// Oldest entry toward the arbiter

	assign result.valid = ~empty;	// Taken when hold is low
	assign result.data1 = bufData[readAddr];
	assign result.data2 = '0;
	assign result.opCode = bufOpCode[readAddr];
	assign result.tag = bufTag[readAddr];

	assign busy = full;

	ringBuffCtrl #(
		.numEntry(`EXEC_DEPTH)
	) ringBuffCtrl0 (
		.clock(clock),
		.reset(reset),
		.writeEn(writeEn),
		.readEn(readEn),
		.writeAddr(writeAddr),
		.readAddr(readAddr),
		.full(full),
		.empty(empty)
	);

endmodule

//--- rtl/mulUnit.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module mulUnit (
	input logic clock,
	input logic reset,
	execIssueIf.sink issue,
	execIssueIf.source result,
	input logic hold,
	output logic busy
);
	import execPkg::*;

	localparam int dataW = $bits(data_t);

	logic [2*dataW-1:0] product;	// Full unsigned product
	logic wantHigh;
	data_t resultData;

	logic writeEn;
	logic readEn;
	bufPtr_t writeAddr;
	bufPtr_t readAddr;
	logic full;
	logic empty;

	data_t bufData [`EXEC_DEPTH];
	tag_t bufTag [`EXEC_DEPTH];
	opCode_t bufOpCode [`EXEC_DEPTH];

	////////////////////////////////////////
	// Multiply and pick one half

	assign product = issue.data1 * issue.data2;
	assign wantHigh = issue.opCode[0];
	assign resultData = wantHigh ? product[2*dataW-1:dataW] : product[dataW-1:0];

	assign writeEn = issue.valid & ~full;
	assign readEn = ~empty & ~hold;

	always_ff @(posedge clock) begin
		if (writeEn) begin
			bufData[writeAddr] <= resultData;
			bufTag[writeAddr] <= issue.tag;
			bufOpCode[writeAddr] <= issue.opCode;
		end
	end

	// Same read side as the add unit
	assign result.valid = ~empty;
	assign result.data1 = bufData[readAddr];
	assign result.data2 = '0;
	assign result.opCode = bufOpCode[readAddr];
	assign result.tag = bufTag[readAddr];

	assign busy = full;	// Lane top shows this as mulBusy

	ringBuffCtrl #(
		.numEntry(`EXEC_DEPTH)
	) ringBuffCtrl0 (
		.clock(clock),
		.reset(reset),
		.writeEn(writeEn),
		.readEn(readEn),
		.writeAddr(writeAddr),
		.readAddr(readAddr),
		.full(full),
		.empty(empty)
	);

endmodule

//--- rtl/resultArbiter.sv
`timescale 1ns/1ps

module resultArbiter (
	input logic clock,
	input logic reset,
	execIssueIf.sink addIn,
	execIssueIf.sink mulIn,
	output logic holdAdd,
	output logic holdMul,
	input logic wbStall,
	output logic wbValid,
	output execPkg::data_t wbData,
	output execPkg::tag_t wbTag,
	output execPkg::opCode_t wbOpCode
);
	import execPkg::*;

	grant_t lastGrant;	// Unit served most recently

	logic accept;
	logic preferMul;
	logic takeAdd;
	logic takeMul;

	////////////////////////////////////////
	// Selection

	// Output stage is free or delivering whenever write-back is not stalled
	assign accept = ~wbStall;

	// Serve the unit that did not go last
	assign preferMul = (lastGrant == grantAdd);

	// A unit loses only when the preferred one also has a result
	assign holdAdd = ~accept | (preferMul & mulIn.valid);
	assign holdMul = ~accept | (~preferMul & addIn.valid);

	assign takeAdd = addIn.valid & ~holdAdd;
	assign takeMul = mulIn.valid & ~holdMul;

	////////////////////////////////////////
	// Write-back stage

	always_ff @(posedge clock) begin
		if (reset) begin
			wbValid <= 1'b0;
			lastGrant <= grantAdd;
		end
		else if (accept) begin
			wbValid <= takeAdd | takeMul;
			if (takeAdd) begin
				lastGrant <= grantAdd;
			end
			else if (takeMul) begin
				lastGrant <= grantMul;
			end
		end
	end

	// Payload registers load only on a take
	always_ff @(posedge clock) begin
		if (takeAdd) begin
			wbData <= addIn.data1;
			wbTag <= addIn.tag;
			wbOpCode <= addIn.opCode;
		end
		else if (takeMul) begin
			wbData <= mulIn.data1;
			wbTag <= mulIn.tag;
			wbOpCode <= mulIn.opCode;
		end
	end

endmodule

//--- rtl/execLane.sv
`timescale 1ns/1ps

module execLane (
	input logic clock,
	input logic reset,
	input logic issueEn,
	input execPkg::data_t issueData1,
	input execPkg::data_t issueData2,
	input execPkg::opCode_t issueOpCode,
	input execPkg::tag_t issueTag,
	output logic addBusy,
	output logic mulBusy,
	input logic wbStall,
	output logic wbValid,
	output execPkg::data_t wbData,
	output execPkg::tag_t wbTag,
	output execPkg::opCode_t wbOpCode
);

	logic toMul;	// Opcode bit 1 picks the multiply unit
	logic holdAdd;
	logic holdMul;

	execIssueIf issueToAdd ();
	execIssueIf issueToMul ();
	execIssueIf addResult ();
	execIssueIf mulResult ();

	////////////////////////////////////////
	// Issue routing

	assign toMul = issueOpCode[1];

	assign issueToAdd.valid = issueEn & ~toMul;
	assign issueToAdd.data1 = issueData1;
	assign issueToAdd.data2 = issueData2;
	assign issueToAdd.opCode = issueOpCode;
	assign issueToAdd.tag = issueTag;

	assign issueToMul.valid = issueEn & toMul;
	assign issueToMul.data1 = issueData1;
	assign issueToMul.data2 = issueData2;
	assign issueToMul.opCode = issueOpCode;
	assign issueToMul.tag = issueTag;

	////////////////////////////////////////
	// Units and write-back

	addUnit addUnit0 (
		.clock(clock),
		.reset(reset),
		.issue(issueToAdd),
		.result(addResult),
		.hold(holdAdd),
		.busy(addBusy)
	);

	mulUnit mulUnit0 (
		.clock(clock),
		.reset(reset),
		.issue(issueToMul),
		.result(mulResult),
		.hold(holdMul),
		.busy(mulBusy)
	);

	resultArbiter resultArbiter0 (
		.clock(clock),
		.reset(reset),
		.addIn(addResult),
		.mulIn(mulResult),
		.holdAdd(holdAdd),
		.holdMul(holdMul),
		.wbStall(wbStall),
		.wbValid(wbValid),
		.wbData(wbData),
		.wbTag(wbTag),
		.wbOpCode(wbOpCode)
	);

endmodule

//--- tb/execLane_sva.sv
`timescale 1ns/1ps

module execLane_sva (
	input logic clock,
	input logic reset,
	input logic issueEn,
	input execPkg::opCode_t issueOpCode,
	input logic addBusy,
	input logic mulBusy,
	input logic wbStall,
	input logic wbValid,
	input execPkg::data_t wbData,
	input execPkg::tag_t wbTag,
	input execPkg::opCode_t wbOpCode
);

	// Write-back frozen while stalled
	stallHold: assert property (@(posedge clock) disable iff (reset)
		wbValid && wbStall |=> wbValid && $stable(wbData) && $stable(wbTag) && $stable(wbOpCode))
		else $error("write-back changed while stalled");

	resetClear: assert property (@(posedge clock)
		reset |=> !wbValid && !addBusy && !mulBusy)
		else $error("lane not idle after reset");

	// Opcode bit 1 names the target unit
	busyIssue: assert property (@(posedge clock) disable iff (reset)
		issueEn |-> !(issueOpCode[1] ? mulBusy : addBusy))
		else $error("issue made to a busy unit");

endmodule

bind execLane execLane_sva execLaneSva0 (
	.clock(clock),
	.reset(reset),
	.issueEn(issueEn),
	.issueOpCode(issueOpCode),
	.addBusy(addBusy),
	.mulBusy(mulBusy),
	.wbStall(wbStall),
	.wbValid(wbValid),
	.wbData(wbData),
	.wbTag(wbTag),
	.wbOpCode(wbOpCode)
);

//--- tb/execLaneTb.sv
`timescale 1ns/1ps

module execLaneTb;
	import execPkg::*;

	localparam int dataW = $bits(data_t);
	localparam int numTag = 1 << $bits(tag_t);
	localparam int lenAdd = 48;
	localparam int lenMul = 48;
	localparam int lenMix = 96;
	localparam int lenStall = 96;
	localparam int lenFull = 16;	// Cap on issues while filling
	localparam int cycleLimit = 20 * (lenAdd + lenMul + lenMix + lenStall + lenFull) + 200;

	logic clock;
	logic reset;
	logic issueEn;
	data_t issueData1;
	data_t issueData2;
	opCode_t issueOpCode;
	tag_t issueTag;
	logic addBusy;
	logic mulBusy;
	logic wbStall;
	logic wbValid;
	data_t wbData;
	tag_t wbTag;
	opCode_t wbOpCode;

	logic [31:0] lfsr = 32'h5e1b;
	int stallMode = 0;	// 0 off, 1 random, 2 held high
	int nextTag = 0;
	int issuedCount = 0;
	int returnedCount = 0;
	int errorCount = 0;	// Compare process only
	int flowErrors = 0;	// Main process only
	int testCount = 0;
	int cycleCount = 0;

	// Per-tag scoreboard where a tag is outstanding while its two marks differ
	data_t expData [numTag];
	opCode_t expOp [numTag];
	bit issuedMark [numTag];
	bit returnedMark [numTag];

	// Write-back seen under stall in the previous cycle
	bit stallSeen = 1'b0;
	data_t heldData;
	tag_t heldTag;
	opCode_t heldOp;

	execLane dut0 (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	////////////////////////////////////////
	// Stimulus helpers

	function automatic data_t randomBits(int n);
		data_t v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v = {v[dataW-2:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic data_t expectedResult(opCode_t op, data_t a, data_t b);
		logic [2*dataW-1:0] wide;
		wide = {{dataW{1'b0}}, a} * {{dataW{1'b0}}, b};
		if (!op[1]) begin
			return op[0] ? a - b : a + b;
		end
		return op[0] ? wide[2*dataW-1:dataW] : wide[dataW-1:0];	// High or low half
	endfunction

	function automatic int freeTag();
		int k;
		int idx;
		for (k = 0; k < numTag; k++) begin
			idx = (nextTag + k) % numTag;
			if (issuedMark[idx] == returnedMark[idx]) begin
				return idx;
			end
		end
		return -1;
	endfunction

	task automatic nextCycle();
		data_t r;
		@(negedge clock);
		issueEn = 1'b0;
		case (stallMode)
			1: begin
				r = randomBits(1);
				wbStall = r[0];
			end
			2: wbStall = 1'b1;
			default: wbStall = 1'b0;
		endcase
	endtask

	task automatic issueOne(opCode_t op);
		data_t a;
		data_t b;
		int t;
		a = randomBits(dataW);
		b = randomBits(dataW);
		while (freeTag() < 0 || (op[1] ? mulBusy : addBusy)) begin
			nextCycle();	// Wait out a full target buffer
		end
		t = freeTag();
		nextTag = (t + 1) % numTag;
		issueEn = 1'b1;
		issueData1 = a;
		issueData2 = b;
		issueOpCode = op;
		issueTag = tag_t'(t);
		expData[t] = expectedResult(op, a, b);
		expOp[t] = op;
		issuedMark[t] = ~issuedMark[t];
		issuedCount++;
		nextCycle();
	endtask

	task automatic randomOps(int n, int unitSel);
		data_t r;
		int i;
		for (i = 0; i < n; i++) begin
			r = randomBits(2);
			if (unitSel >= 0) begin
				r[1] = unitSel[0];
			end
			issueOne(r[1:0]);
		end
	endtask

	////////////////////////////////////////
	// Checks and reporting

	task automatic checkData(data_t actual, data_t expected, tag_t tag, inout int errs);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: tag %0d data %h, expected %h", $time, tag, actual, expected);
			errs++;
		end
	endtask

	task automatic checkOpCode(opCode_t actual, opCode_t expected, tag_t tag, inout int errs);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: tag %0d opcode %b, expected %b", $time, tag, actual, expected);
			errs++;
		end
	endtask

	task automatic checkTag(tag_t actual, tag_t expected, inout int errs);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: tag %0d, expected %0d", $time, actual, expected);
			errs++;
		end
	endtask

	task automatic checkFlag(logic actual, logic expected, string name, inout int errs);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, name, actual, expected);
			errs++;
		end
	endtask

	task automatic finishTest(string name, int issuedBefore, int errBefore);
		stallMode = 0;
		while (returnedCount != issuedCount) begin
			nextCycle();
		end
		repeat (8) nextCycle();	// Catch stray results
		if (returnedCount != issuedCount) begin
			$display("Test %s returned %0d results for %0d operations", name, returnedCount,
				issuedCount);
			flowErrors++;
		end
		testCount++;
		$display("Test %0d %s: %0d operations, %0d errors", testCount, name,
			issuedCount - issuedBefore, errorCount + flowErrors - errBefore);
	endtask

	// Scoreboard compare on every delivered result
	always @(posedge clock) begin
		// A stalled write-back keeps its payload
		if (!reset && stallSeen) begin
			checkFlag(wbValid, 1'b1, "wbValid under stall", errorCount);
			checkData(wbData, heldData, heldTag, errorCount);
			checkTag(wbTag, heldTag, errorCount);
			checkOpCode(wbOpCode, heldOp, heldTag, errorCount);
		end
		stallSeen = !reset && wbValid === 1'b1 && wbStall === 1'b1;
		heldData = wbData;
		heldTag = wbTag;
		heldOp = wbOpCode;

		if (!reset && wbValid === 1'b1 && wbStall === 1'b0) begin
			if ($isunknown(wbTag) || issuedMark[wbTag] == returnedMark[wbTag]) begin
				$display("Result with unknown or already returned tag %0d at %0t ns", wbTag, $time);
				errorCount++;
			end
			else begin
				checkData(wbData, expData[wbTag], wbTag, errorCount);
				checkOpCode(wbOpCode, expOp[wbTag], wbTag, errorCount);
				returnedMark[wbTag] = ~returnedMark[wbTag];
				returnedCount++;
			end
		end
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("Timeout after %0d cycles with results still missing", cycleCount);
			$display("Errors found");
			$finish;
		end
	end

	////////////////////////////////////////
	// Test sequence

	initial begin
		int n;
		int issuedBefore;
		int errBefore;
		data_t r;
		issueEn = 1'b0;
		issueData1 = '0;
		issueData2 = '0;
		issueOpCode = '0;
		issueTag = '0;
		wbStall = 1'b0;
		reset = 1'b1;
		repeat (3) @(negedge clock);
		reset = 1'b0;

		errBefore = flowErrors;
		checkFlag(wbValid, 1'b0, "wbValid", flowErrors);
		checkFlag(addBusy, 1'b0, "addBusy", flowErrors);
		checkFlag(mulBusy, 1'b0, "mulBusy", flowErrors);
		testCount++;
		$display("Test 1 reset: %0d errors", flowErrors - errBefore);

		issuedBefore = issuedCount;
		errBefore = errorCount + flowErrors;
		randomOps(lenAdd, 0);
		finishTest("add/sub", issuedBefore, errBefore);

		issuedBefore = issuedCount;
		errBefore = errorCount + flowErrors;
		randomOps(lenMul, 1);
		finishTest("multiply", issuedBefore, errBefore);

		issuedBefore = issuedCount;
		errBefore = errorCount + flowErrors;
		randomOps(lenMix, -1);
		finishTest("interleaved", issuedBefore, errBefore);

		issuedBefore = issuedCount;
		errBefore = errorCount + flowErrors;
		stallMode = 1;
		randomOps(lenStall, -1);
		finishTest("random stall", issuedBefore, errBefore);

		// Fill both buffers behind a held stall
		issuedBefore = issuedCount;
		errBefore = errorCount + flowErrors;
		stallMode = 2;
		nextCycle();
		n = 0;
		while (!(addBusy && mulBusy) && n < lenFull) begin
			r = randomBits(1);
			if (addBusy) begin
				issueOne({1'b1, r[0]});
			end
			else if (mulBusy) begin
				issueOne({1'b0, r[0]});
			end
			else begin
				issueOne({n[0], r[0]});	// Alternate units
			end
			n++;
		end
		if (!(addBusy && mulBusy)) begin
			$display("Busy flags did not both rise while write-back was stalled");
			flowErrors++;
		end
		finishTest("full buffers", issuedBefore, errBefore);

		$display("Tests: %0d, operations: %0d, results: %0d, errors: %0d", testCount, issuedCount,
			returnedCount, errorCount + flowErrors);
		if (errorCount + flowErrors == 0) begin
			$display("No errors");
		end
		else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- build.f
+incdir+rtl
rtl/execPkg.sv
rtl/execIssueIf.sv
rtl/ringBuffCtrl.sv
rtl/addUnit.sv
rtl/mulUnit.sv
rtl/resultArbiter.sv
rtl/execLane.sv
tb/execLane_sva.sv
tb/execLaneTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP = execLaneTb
FILELIST = build.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "No errors" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
